// ==== hdl/addr_pkg.sv ====
/*
 * Address datapath types for the per-thread offset unit.
 * Covers address and thread widths plus the tagged request and response payloads.
 */

package addr_pkg;

    // ----------------------------------------
    // widths
    // ----------------------------------------

    localparam int ADDR_W   = 16;  // address and offset word
    localparam int THREAD_W = 3;   // up to 8 hardware threads

    // ----------------------------------------
    // scalar types
    // ----------------------------------------

    typedef logic [ADDR_W-1:0]   addr_t;
    typedef logic [THREAD_W-1:0] thread_id_t;

    // ----------------------------------------
    // payloads
    // ----------------------------------------

    // address tagged with the thread that owns this cycle
    typedef struct packed {
        logic       valid;
        thread_id_t thread;
        addr_t      addr;
    } addr_req_t;

    // translated address leaving the unit
    typedef struct packed {
        logic       valid;
        thread_id_t thread;  // thread the offset came from
        addr_t      addr;    // input address plus offset, wraps
    } addr_rsp_t;

endpackage

// ==== hdl/wb_pkg.sv ====
/*
 * Wishbone classic structs for the offset configuration port.
 * The address field selects a thread, the data field carries its offset.
 */

package wb_pkg;

    import addr_pkg::*;

    // master to slave
    typedef struct packed {
        logic       cyc;
        logic       stb;
        logic       we;
        thread_id_t adr;  // thread index, not a byte address
        addr_t      dat;
    } wb_req_t;

    // slave to master
    typedef struct packed {
        logic  ack;
        logic  err;   // reads and bad indices
        addr_t dat;   // unused, no read path
    } wb_rsp_t;

endpackage

// ==== hdl/thread_sequencer.sv ====
/*
 * Thread sequencer. Keeps the round-robin thread count and registers
 * each incoming address together with the thread that owns this cycle.
 */

`timescale 1ns/1ps

module thread_sequencer
    import addr_pkg::*;
#(
    parameter int unsigned THREAD_COUNT   = 8,
    parameter int unsigned INITIAL_THREAD = 0
)
(
    input  logic      clock,
    input  logic      rst_n,
    input  addr_req_t addr_in,     // thread field ignored
    output addr_req_t req_tagged
);

    localparam thread_id_t LAST_THREAD  = thread_id_t'(THREAD_COUNT - 1);
    localparam thread_id_t FIRST_THREAD = thread_id_t'(INITIAL_THREAD);

    thread_id_t thread_cnt;  // thread of the next sampled address

    // ----------------------------------------
    // counter and tag register
    // ----------------------------------------

    always_ff @(posedge clock) begin
        if (!rst_n) begin
            thread_cnt       <= FIRST_THREAD;
            req_tagged.valid <= 1'b0;
        end else begin
            req_tagged.valid  <= addr_in.valid;
            req_tagged.thread <= thread_cnt;
            req_tagged.addr   <= addr_in.addr;
            if (thread_cnt == LAST_THREAD) begin
                thread_cnt <= '0;  // wrap
            end else begin
                thread_cnt <= thread_cnt + 1'b1;
            end
        end
    end

    // the offset memory has only THREAD_COUNT words, so a tag past the end
    // would read an undefined offset
    assert property (@(posedge clock) disable iff (!rst_n)
        thread_cnt < THREAD_COUNT)
        else $error("thread counter left range 0..%0d", THREAD_COUNT - 1);

endmodule

// ==== hdl/offset_ram.sv ====
/*
 * Offset memory. Simple dual port, one write port from the bus side and
 * one registered read port for the pipeline, old data on a collision.
 */

`timescale 1ns/1ps

module offset_ram
    import addr_pkg::*;
#(
    parameter int unsigned DEPTH = 8
)
(
    input  logic       clock,
    input  logic       wr_en,
    input  thread_id_t wr_thread,
    input  addr_t      wr_offset,
    input  thread_id_t rd_thread,
    output addr_t      rd_offset
);

    addr_t mem [DEPTH];  // one offset word per thread

    // ----------------------------------------
    // write port
    // ----------------------------------------

    always_ff @(posedge clock) begin
        if (wr_en) begin
            mem[wr_thread] <= wr_offset;
        end
    end

    // ----------------------------------------
    // read port
    // ----------------------------------------

    // registered read, a same-edge write is not forwarded
    always_ff @(posedge clock) begin
        rd_offset <= mem[rd_thread];
    end

endmodule

// ==== hdl/offset_wb_slave.sv ====
/*
 * Wishbone classic slave for the offset memory. Each new cycle gives at most
 * one offset write and one single-cycle ack, or err for reads and bad indices.
 */

`timescale 1ns/1ps

module offset_wb_slave
    import addr_pkg::*;
    import wb_pkg::*;
#(
    parameter int unsigned THREAD_COUNT = 8
)
(
    input  logic       clock,
    input  logic       rst_n,
    input  wb_req_t    wb_in,
    output wb_rsp_t    wb_out,
    output logic       wr_en,
    output thread_id_t wr_thread,
    output addr_t      wr_offset
);

    logic req_live;   // cyc and stb both high
    logic req_seen;   // request was already live last edge
    logic new_req;
    logic in_range;
    logic accept;     // valid write to an existing thread
    logic ack_q;
    logic err_q;

    assign req_live = wb_in.cyc && wb_in.stb;
    assign new_req  = req_live && !req_seen;  // held requests answered once
    assign in_range = (wb_in.adr < THREAD_COUNT);
    assign accept   = wb_in.we && in_range;

    // ----------------------------------------
    // response registers
    // ----------------------------------------

    always_ff @(posedge clock) begin
        if (!rst_n) begin
            req_seen <= 1'b0;
            ack_q    <= 1'b0;
            err_q    <= 1'b0;
        end else begin
            req_seen <= req_live;
            ack_q    <= new_req && accept;
            err_q    <= new_req && !accept;  // read or index past the end
        end
    end

    // memory write lands on the same edge that raises ack
    assign wr_en     = new_req && accept;
    assign wr_thread = wb_in.adr;
    assign wr_offset = wb_in.dat;

    assign wb_out = '{ack: ack_q, err: err_q, dat: '0};

    // a response is seen only while the master still holds its cycle open
    assert property (@(posedge clock) disable iff (!rst_n)
        (wb_out.ack || wb_out.err) |->
            wb_in.cyc && !(wb_out.ack && wb_out.err))
        else $error("wishbone response outside a cycle, or ack with err");

endmodule

// ==== hdl/pipe_delay.sv ====
/*
 * Fixed-depth delay line for any packed payload.
 * Every stage clears on reset so embedded valid bits start low.
 */

`timescale 1ns/1ps

module pipe_delay #(
    parameter type         payload_t = logic,
    parameter int unsigned DEPTH     = 1       // at least one stage
)
(
    input  logic     clock,
    input  logic     rst_n,
    input  payload_t din,
    output payload_t dout
);

    payload_t stage [DEPTH];

    always_ff @(posedge clock) begin
        if (!rst_n) begin
            for (int i = 0; i < DEPTH; i++) begin
                stage[i] <= '0;
            end
        end else begin
            stage[0] <= din;
            for (int i = 1; i < DEPTH; i++) begin
                stage[i] <= stage[i-1];  // shift toward dout
            end
        end
    end

    assign dout = stage[DEPTH-1];

endmodule

// ==== hdl/thread_addressing.sv ====
/*
 * Offset adder. Lines up each tagged address with the offset read for its
 * thread, adds them in a registered adder and retimes the sum to the output.
 */

`timescale 1ns/1ps

module thread_addressing
    import addr_pkg::*;
#(
    parameter int unsigned OUT_STAGES = 1
)
(
    input  logic       clock,
    input  logic       rst_n,
    input  addr_req_t  req_tagged,
    output thread_id_t rd_thread,
    input  addr_t      rd_offset,
    output addr_rsp_t  addr_out
);

    localparam int unsigned LATENCY = 2 + OUT_STAGES;  // tag register to addr_out

    addr_req_t req_aligned;  // same cycle as rd_offset
    addr_rsp_t sum_q;

    // offset read starts straight from the tag
    assign rd_thread = req_tagged.thread;

    // ----------------------------------------
    // align with the memory read
    // ----------------------------------------

    pipe_delay #(
        .payload_t (addr_req_t),
        .DEPTH     (1)
    ) align_delay (
        .clock (clock),
        .rst_n (rst_n),
        .din   (req_tagged),
        .dout  (req_aligned)
    );

    // ----------------------------------------
    // registered adder
    // ----------------------------------------

    always_ff @(posedge clock) begin
        if (!rst_n) begin
            sum_q.valid <= 1'b0;
        end else begin
            sum_q.valid  <= req_aligned.valid;
            sum_q.thread <= req_aligned.thread;
            sum_q.addr   <= req_aligned.addr + rd_offset;  // wraps mod 2**ADDR_W
        end
    end

    // ----------------------------------------
    // output retiming
    // ----------------------------------------

    pipe_delay #(
        .payload_t (addr_rsp_t),
        .DEPTH     (OUT_STAGES)
    ) out_delay (
        .clock (clock),
        .rst_n (rst_n),
        .din   (sum_q),
        .dout  (addr_out)
    );

    // the valid and its thread tag travel together through both delay lines
    assert property (@(posedge clock) disable iff (!rst_n)
        addr_out.valid |->
            $past(req_tagged.valid, LATENCY) &&
            (addr_out.thread == $past(req_tagged.thread, LATENCY)))
        else $error("output valid not matched by input %0d cycles earlier", LATENCY);

endmodule

// ==== hdl/addressing_top.sv ====
/*
 * Per-thread address offset unit. Tags each address with its round-robin
 * thread and adds that thread's offset, written over a Wishbone port.
 */

`timescale 1ns/1ps

module addressing_top
    import addr_pkg::*;
    import wb_pkg::*;
#(
    parameter int unsigned THREAD_COUNT   = 8,  // at most 2**THREAD_W
    parameter int unsigned INITIAL_THREAD = 0,
    parameter int unsigned OUT_STAGES     = 1   // at least 1
)
(
    input  logic      clock,
    input  logic      rst_n,
    input  addr_req_t addr_in,
    output addr_rsp_t addr_out,
    input  wb_req_t   wb_in,
    output wb_rsp_t   wb_out
);

    addr_req_t  req_tagged;
    thread_id_t rd_thread;
    addr_t      rd_offset;
    logic       wr_en;
    thread_id_t wr_thread;
    addr_t      wr_offset;

    thread_sequencer #(
        .THREAD_COUNT   (THREAD_COUNT),
        .INITIAL_THREAD (INITIAL_THREAD)
    ) sequencer (
        .clock      (clock),
        .rst_n      (rst_n),
        .addr_in    (addr_in),
        .req_tagged (req_tagged)
    );

    offset_ram #(
        .DEPTH (THREAD_COUNT)
    ) offsets (
        .clock     (clock),
        .wr_en     (wr_en),
        .wr_thread (wr_thread),
        .wr_offset (wr_offset),
        .rd_thread (rd_thread),
        .rd_offset (rd_offset)
    );

    offset_wb_slave #(
        .THREAD_COUNT (THREAD_COUNT)
    ) cfg_port (
        .clock     (clock),
        .rst_n     (rst_n),
        .wb_in     (wb_in),
        .wb_out    (wb_out),
        .wr_en     (wr_en),
        .wr_thread (wr_thread),
        .wr_offset (wr_offset)
    );

    thread_addressing #(
        .OUT_STAGES (OUT_STAGES)
    ) adder (
        .clock      (clock),
        .rst_n      (rst_n),
        .req_tagged (req_tagged),
        .rd_thread  (rd_thread),
        .rd_offset  (rd_offset),
        .addr_out   (addr_out)
    );

endmodule

// ==== testbench/tb_addressing.sv ====
/*
 * Testbench for the per-thread address offset unit. Runs a table of bus
 * accesses and address bursts against a model of offsets and thread order.
 */

`timescale 1ns/1ps

module tb_addressing
    import addr_pkg::*;
    import wb_pkg::*;
();

    localparam int unsigned THREAD_COUNT   = 8;
    localparam int unsigned INITIAL_THREAD = 0;
    localparam int unsigned OUT_STAGES     = 1;
    localparam int unsigned LATENCY        = 2 + OUT_STAGES;  // sample edge to addr_out
    localparam int unsigned RESET_CYCLES   = 5;
    localparam int unsigned CYCLES_PER_ROW = 40;
    localparam logic [31:0] SEED           = 32'he1d0830f;
    localparam logic [1:0]  RSP_NONE       = 2'b00;
    localparam logic [1:0]  RSP_ACK        = 2'b10;  // {ack, err}
    localparam logic [1:0]  RSP_ERR        = 2'b01;

    typedef enum logic [1:0] {OP_WRITE, OP_READ, OP_BURST} op_e;

    typedef struct {
        string       name;
        op_e         op;
        int unsigned arg;    // thread index, or burst length
        addr_t       value;  // offset, or gap enable for a burst
        logic [1:0]  rsp;    // expected {ack, err}
    } row_t;

    logic      clock = 1'b0;
    logic      rst_n;
    addr_req_t addr_in;
    addr_rsp_t addr_out;
    wb_req_t   wb_in;
    wb_rsp_t   wb_out;

    row_t        rows [$];
    addr_rsp_t   exp_q [$];            // expected outputs, oldest first
    addr_t       offsets [THREAD_COUNT];  // model of the offset memory
    thread_id_t  next_thread;          // thread of the next sampled edge
    int unsigned ack_count = 0;
    int unsigned err_count = 0;
    string       cur_name = "reset";
    logic        table_ready = 1'b0;

    addr_t offset_init [8] = '{16'h0010, 16'h0200, 16'h3000, 16'hC000,
                               16'h0FFF, 16'h8001, 16'hF0F0, 16'hFFFF};

    addressing_top #(
        .THREAD_COUNT   (THREAD_COUNT),
        .INITIAL_THREAD (INITIAL_THREAD),
        .OUT_STAGES     (OUT_STAGES)
    ) UUT (
        .clock    (clock),
        .rst_n    (rst_n),
        .addr_in  (addr_in),
        .addr_out (addr_out),
        .wb_in    (wb_in),
        .wb_out   (wb_out)
    );

    always #50 clock = ~clock;  // 100 ns period

    // ----------------------------------------
    // helpers
    // ----------------------------------------

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        if (expected !== actual) begin
            $display("mismatch in %s: expected %h, actual %h", name, expected, actual);
            $display("sim failed");
            $fatal(1);
        end
    endtask

    task automatic add_row(input string name, input op_e op, input int unsigned arg,
                           input addr_t value, input logic [1:0] rsp);
        row_t r;
        r.name  = name;
        r.op    = op;
        r.arg   = arg;
        r.value = value;
        r.rsp   = rsp;
        rows.push_back(r);
    endtask

    // one Wishbone cycle, then idle so stb is seen low
    task automatic bus_access(input string name, input logic we, input int unsigned idx,
                              input addr_t value, input logic [1:0] exp_rsp);
        int unsigned ack_base;
        int unsigned err_base;
        logic [1:0]  rsp;
        ack_base = ack_count;
        err_base = err_count;
        wb_in = '{cyc: 1'b1, stb: 1'b1, we: we, adr: thread_id_t'(idx), dat: value};
        @(negedge clock);
        while (!(wb_out.ack || wb_out.err)) begin
            @(negedge clock);
        end
        rsp = {wb_out.ack, wb_out.err};
        if (wb_out.ack) begin
            offsets[idx] = value;  // model follows the acked write
        end
        @(posedge clock);
        #10;
        wb_in.cyc = 1'b0;
        wb_in.stb = 1'b0;
        repeat (2) begin
            @(posedge clock);
            #10;
        end
        check_value(name, exp_rsp, rsp);
        check_value({name, " acks"}, exp_rsp[1], ack_count - ack_base);
        check_value({name, " errs"}, exp_rsp[0], err_count - err_base);
    endtask

    task automatic run_burst(input int unsigned count, input logic gaps);
        for (int unsigned i = 0; i < count; i++) begin
            addr_in.valid  = gaps ? ($urandom_range(3, 0) != 0) : 1'b1;
            addr_in.thread = '0;
            addr_in.addr   = addr_t'($urandom());
            @(posedge clock);
            #10;
        end
        addr_in.valid = 1'b0;
        repeat (LATENCY + 1) begin  // drain before the bus moves again
            @(posedge clock);
            #10;
        end
    endtask

    // ----------------------------------------
    // output model and compare
    // ----------------------------------------

    // at a negedge addr_in shows what the next edge samples,
    // and addr_out shows the result of the edge just past
    always @(negedge clock) begin : monitor
        addr_rsp_t expected;
        addr_rsp_t sample;
        if (!rst_n) begin
            exp_q.delete();
            repeat (LATENCY + 1) exp_q.push_back('0);
            next_thread = thread_id_t'(INITIAL_THREAD);
        end else begin
            expected = exp_q.pop_front();
            if (!expected.valid) begin
                check_value({cur_name, " valid"}, 0, addr_out.valid);
            end else if ($isunknown(expected.addr)) begin
                check_value({cur_name, " tag"}, {expected.valid, expected.thread},
                            {addr_out.valid, addr_out.thread});
            end else begin
                check_value(cur_name, expected, addr_out);
            end
            sample.valid  = addr_in.valid;
            sample.thread = next_thread;
            sample.addr   = addr_in.addr + offsets[next_thread];  // wraps
            exp_q.push_back(sample);
            next_thread = (next_thread == THREAD_COUNT - 1) ? '0 : next_thread + 1'b1;
            ack_count += wb_out.ack;
            err_count += wb_out.err;
        end
    end

    // ----------------------------------------
    // watchdog
    // ----------------------------------------

    initial begin
        int unsigned limit;
        wait (table_ready);
        limit = rows.size() * CYCLES_PER_ROW + RESET_CYCLES;
        repeat (limit) @(posedge clock);
        $display("simulation timed out after %0d cycles", limit);
        $display("sim failed");
        $fatal(1);
    end

    // ----------------------------------------
    // stimulus table and main sequence
    // ----------------------------------------

    initial begin
        rst_n   = 1'b0;
        addr_in = '0;
        wb_in   = '0;
        foreach (offsets[t]) offsets[t] = 'x;  // memory holds no offsets yet
        void'($urandom(SEED));

        add_row("first_burst", OP_BURST, 12, 16'h0, RSP_NONE);  // tags only
        for (int unsigned t = 0; t < THREAD_COUNT; t++) begin
            add_row($sformatf("write_t%0d", t), OP_WRITE, t, offset_init[t], RSP_ACK);
        end
        add_row("burst_all", OP_BURST, 20, 16'h0, RSP_NONE);
        add_row("read_err", OP_READ, 2, 16'h0, RSP_NONE | RSP_ERR);
        if (THREAD_COUNT < 2 ** THREAD_W) begin  // index not encodable otherwise
            add_row("bad_index", OP_WRITE, THREAD_COUNT, 16'hDEAD, RSP_ERR);
        end
        add_row("burst_after_err", OP_BURST, 16, 16'h0, RSP_NONE);
        add_row("rewrite_t5", OP_WRITE, 5, 16'h1234, RSP_ACK);
        add_row("burst_rewrite", OP_BURST, 16, 16'h0, RSP_NONE);
        add_row("gap_burst", OP_BURST, 24, 16'h1, RSP_NONE);
        add_row("gap_burst_2", OP_BURST, 17, 16'h1, RSP_NONE);
        table_ready = 1'b1;

        repeat (RESET_CYCLES) @(posedge clock);
        #10;
        rst_n = 1'b1;
        check_value("reset", 0, {wb_out.ack, wb_out.err, addr_out.valid});

        foreach (rows[i]) begin
            cur_name = rows[i].name;
            case (rows[i].op)
                OP_WRITE: bus_access(rows[i].name, 1'b1, rows[i].arg, rows[i].value,
                                     rows[i].rsp);
                OP_READ:  bus_access(rows[i].name, 1'b0, rows[i].arg, rows[i].value,
                                     rows[i].rsp);
                default:  run_burst(rows[i].arg, rows[i].value != 0);
            endcase
        end

        $display("sim passed");
        $finish;
    end

endmodule

// ==== all.f ====
hdl/addr_pkg.sv
hdl/wb_pkg.sv
hdl/thread_sequencer.sv
hdl/offset_ram.sv
hdl/offset_wb_slave.sv
hdl/pipe_delay.sv
hdl/thread_addressing.sv
hdl/addressing_top.sv
testbench/tb_addressing.sv

// ==== Bender.yml ====
package:
  name: thread_addressing

sources:
  - hdl/addr_pkg.sv
  - hdl/wb_pkg.sv
  - hdl/thread_sequencer.sv
  - hdl/offset_ram.sv
  - hdl/offset_wb_slave.sv
  - hdl/pipe_delay.sv
  - hdl/thread_addressing.sv
  - hdl/addressing_top.sv
  - target: simulation
    files:
      - testbench/tb_addressing.sv
